// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_tft
FILELIST  ?= verilog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

// File: ahb_pkg.sv
package ahb_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_busy   = 2'b01,
        trans_nonseq = 2'b10,
        trans_seq    = 2'b11
    } trans_t;

    typedef enum logic [2:0] {
        burst_single = 3'b000,
        burst_incr   = 3'b001,
        burst_wrap4  = 3'b010,
        burst_incr4  = 3'b011,
        burst_wrap8  = 3'b100,
        burst_incr8  = 3'b101,
        burst_wrap16 = 3'b110,
        burst_incr16 = 3'b111
    } burst_t;

    // Only word transfers are issued here
    typedef enum logic [2:0] {
        size_byte  = 3'b000,
        size_half  = 3'b001,
        size_word  = 3'b010,
        size_dword = 3'b011
    } size_t;

    typedef enum logic {
        resp_okay  = 1'b0,
        resp_error = 1'b1
    } resp_t;

endpackage

// File: fifo_async.sv
module fifo_async (
    input  logic           HCLK,
    input  logic           HRESET,
    input  ahb_pkg::data_t wr_data,
    input  logic           wr_req,
    output logic           wr_ack,

    input  logic           clk_tft,
    input  logic           reset_tft,
    output ahb_pkg::data_t rd_data,
    output logic           rd_req,
    input  logic           rd_ack
);
    import ahb_pkg::*;
    import tft_pkg::*;

    data_t mem [fifo_depth];

    // Pointers carry one extra wrap bit
    logic [fifo_aw:0] wr_bin;
    logic [fifo_aw:0] wr_bin_next;
    logic [fifo_aw:0] wr_gray;
    logic [fifo_aw:0] rd_bin;
    logic [fifo_aw:0] rd_bin_next;
    logic [fifo_aw:0] rd_gray;

    logic [fifo_aw:0] rd_gray_meta;
    logic [fifo_aw:0] rd_gray_wr;
    logic [fifo_aw:0] wr_gray_meta;
    logic [fifo_aw:0] wr_gray_rd;

    logic wr_en;
    logic rd_en;
    logic full;
    logic empty;

    function automatic logic [fifo_aw:0] bin2gray(input logic [fifo_aw:0] b);
        return b ^ (b >> 1);
    endfunction

    // Write side
    assign full = (wr_gray == {~rd_gray_wr[fifo_aw:fifo_aw-1], rd_gray_wr[fifo_aw-2:0]});
    assign wr_ack      = !full;
    assign wr_en       = wr_req && wr_ack;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge HCLK) begin
        if (wr_en) begin
            mem[wr_bin[fifo_aw-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_en) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
        end
    end

    always_ff @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            rd_gray_meta <= '0;
            rd_gray_wr   <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_wr   <= rd_gray_meta;
        end
    end

    // Read side
    assign empty       = (rd_gray == wr_gray_rd);
    assign rd_req      = !empty;
    assign rd_en       = rd_req && rd_ack;
    assign rd_bin_next = rd_bin + 1'b1;
    assign rd_data     = mem[rd_bin[fifo_aw-1:0]];

    always_ff @(posedge clk_tft, posedge reset_tft) begin
        if (reset_tft) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_en) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
        end
    end

    always_ff @(posedge clk_tft, posedge reset_tft) begin
        if (reset_tft) begin
            wr_gray_meta <= '0;
            wr_gray_rd   <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_rd   <= wr_gray_meta;
        end
    end

endmodule

// File: tb_ahb_memory.sv
module tb_ahb_memory (
    input  logic            HCLK,
    input  logic            HRESET,
    input  logic [1:0]      wait_mode,
    input  ahb_pkg::addr_t  haddr,
    input  ahb_pkg::trans_t htrans,
    output logic            hready,
    output ahb_pkg::data_t  hrdata,
    output ahb_pkg::resp_t  hresp
);
    timeunit 1ns;
    timeprecision 100ps;
    import ahb_pkg::*;

    localparam logic [1:0]  wait_random = 2'd1;
    localparam logic [1:0]  wait_stall  = 2'd2;
    localparam logic [31:0] seed        = 32'd59223;

    logic        pending;
    logic [1:0]  wait_cnt;
    addr_t       addr_q;
    logic [31:0] rnd;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Pattern word for any byte address
    function automatic data_t word_at(input addr_t a);
        logic [31:0] x;
        x = seed ^ a;
        x = xorshift(x);
        x = xorshift(x);
        return x;
    endfunction

    // Stall mode also blocks the address phase
    assign hready = !(pending && wait_cnt != 2'd0) && (wait_mode != wait_stall);
    assign hrdata = word_at(addr_q);
    assign hresp  = resp_okay;

    always @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            addr_q   <= '0;
            rnd      <= seed;
        end else if (hready && htrans == trans_nonseq) begin
            pending <= 1'b1;
            addr_q  <= haddr;
            rnd     <= xorshift(rnd);
            // About one beat in four gets one or two wait states
            if (wait_mode == wait_random && rnd[1:0] == 2'b00) begin
                wait_cnt <= {1'b0, rnd[2]} + 2'd1;
            end else begin
                wait_cnt <= 2'd0;
            end
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (hready) begin
            pending <= 1'b0;
        end
    end

endmodule

// File: tb_tft.sv
module tb_tft;
    timeunit 1ns;
    timeprecision 100ps;
    import ahb_pkg::*;
    import tft_pkg::*;

    localparam logic [1:0] wait_none   = 2'd0;
    localparam logic [1:0] wait_random = 2'd1;
    localparam logic [1:0] wait_stall  = 2'd2;

    // What the pixel monitor expects in the current frame
    localparam int frame_skip  = 0;
    localparam int frame_data  = 1;
    localparam int frame_empty = 2;

    typedef struct packed {
        logic [1:0] mode;
        int         frames;
        logic       uflow;
    } row_t;

    localparam int n_rows = 5;
    localparam row_t rows [n_rows] = '{
        '{wait_none,   3, 1'b0},
        '{wait_random, 3, 1'b0},
        '{wait_stall,  2, 1'b1},
        '{wait_none,   2, 1'b0},
        '{wait_random, 2, 1'b0}
    };

    logic       HCLK;
    logic       HRESET;
    logic       clk_tft;
    logic       reset_tft;
    logic [1:0] wait_mode;

    addr_t  haddr;
    burst_t hburst;
    size_t  hsize;
    trans_t htrans;
    logic   hwrite;
    data_t  hwdata;
    data_t  hrdata;
    logic   hready;
    resp_t  hresp;
    logic   underflow;
    logic   tft_dclk;
    logic   tft_disp;
    logic   tft_hsync;
    logic   tft_vsync;
    pixel_t tft_rgb;

    int   frame_check;
    int   addr_idx;
    int   h_pos;
    int   v_line;
    logic hs_q;
    logic vs_q;
    bit   locked;
    bit   prev_stall;

    tft u_dut (
        .HCLK(HCLK), .HRESET(HRESET),
        .haddr(haddr), .hburst(hburst), .hsize(hsize), .htrans(htrans),
        .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hready(hready),
        .hresp(hresp), .clk_tft(clk_tft), .reset_tft(reset_tft),
        .underflow(underflow), .tft_dclk(tft_dclk), .tft_disp(tft_disp),
        .tft_hsync(tft_hsync), .tft_vsync(tft_vsync), .tft_rgb(tft_rgb)
    );

    tb_ahb_memory u_mem (
        .HCLK(HCLK), .HRESET(HRESET), .wait_mode(wait_mode),
        .haddr(haddr), .htrans(htrans), .hready(hready),
        .hrdata(hrdata), .hresp(hresp)
    );

    always #2 HCLK = ~HCLK;
    always #3 clk_tft = ~clk_tft;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_sync(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Close out a frame at its vsync and rearm the address count
    task automatic close_frame();
        if (frame_check == frame_data) begin
            check_sync("reads per frame", addr_idx, frame_words);
        end
        addr_idx = 0;
    endtask

    // Address phases accepted by the slave
    always @(posedge HCLK) begin
        if (!HRESET && hready && htrans == trans_nonseq) begin
            if (addr_idx >= frame_words) begin
                stop_run("DMA issued more reads than one frame holds");
            end
            check_addr("haddr", haddr, frame_base + 32'(addr_idx * 4));
            check_sync("hsize", int'(hsize), int'(size_word));
            check_sync("hburst", int'(hburst), int'(burst_single));
            check_flag("hwrite", hwrite, 1'b0);
            check_data("hwdata", hwdata, 32'h0);
            addr_idx = addr_idx + 1;
        end
    end

    // Panel clock output is the inverted panel clock
    always @(clk_tft) begin
        #1;
        check_flag("tft_dclk", tft_dclk, !clk_tft);
    end

    // Raster position rebuilt from the sync outputs
    always @(negedge clk_tft) begin
        bit     disp;
        int     idx;
        data_t  w;
        pixel_t exp_pix;
        if (!reset_tft) begin
            if (!tft_hsync && hs_q) begin
                if (locked) check_sync("clocks per line", h_pos + 1, h_total);
                h_pos = 0;
                if (!tft_vsync && vs_q) begin
                    if (locked) check_sync("lines per frame", v_line + 1, v_total);
                    v_line = 0;
                    locked = 1'b1;
                end else begin
                    v_line = v_line + 1;
                end
            end else begin
                h_pos = h_pos + 1;
            end
            if (locked) begin
                check_flag("tft_disp", tft_disp, 1'b1);
                if (tft_hsync && !hs_q) check_sync("hsync low clocks", h_pos, h_sync);
                if (tft_vsync && !vs_q) check_sync("vsync low lines", v_line, v_sync);
                disp = (h_pos >= h_sync + h_back) && (h_pos < h_sync + h_back + h_disp)
                    && (v_line >= v_sync + v_back) && (v_line < v_sync + v_back + v_disp);
                if (frame_check != frame_skip) begin
                    check_flag("underflow", underflow, disp && frame_check == frame_empty);
                    if (disp) begin
                        exp_pix = '0;
                        if (frame_check == frame_data) begin
                            idx = (v_line - v_sync - v_back) * h_disp + h_pos - h_sync - h_back;
                            w = u_mem.word_at(frame_base + 32'(idx * 4));
                            exp_pix = w[tft_width-1:0];
                        end
                        check_pixel("tft_rgb", tft_rgb, exp_pix);
                    end
                end
            end
            hs_q = tft_hsync;
            vs_q = tft_vsync;
        end
    end

    // Run limit from the table length
    initial begin
        int frames;
        frames = 2;
        for (int r = 0; r < n_rows; r++) frames = frames + rows[r].frames;
        #(frames * 98 * 6 * 2);
        stop_run("timeout: the run went past its time limit");
    end

    initial begin
        HCLK        = 1'b0;
        clk_tft     = 1'b0;
        HRESET      = 1'b1;
        reset_tft   = 1'b1;
        wait_mode   = wait_none;
        frame_check = frame_skip;
        addr_idx    = 0;
        h_pos       = 0;
        v_line      = 0;
        hs_q        = 1'b1;
        vs_q        = 1'b1;
        locked      = 1'b0;
        prev_stall  = 1'b0;
        repeat (8) @(negedge HCLK);
        HRESET    = 1'b0;
        reset_tft = 1'b0;

        // First frame after reset is not checked
        @(negedge tft_vsync);
        for (int r = 0; r < n_rows; r++) begin
            for (int f = 0; f < rows[r].frames; f++) begin
                @(negedge tft_vsync);
                close_frame();
                frame_check = rows[r].uflow ? frame_empty : frame_data;
                if (f == 0) begin
                    // Leaving a stall waits until the DMA has restarted at the base
                    if (prev_stall) repeat (6) @(posedge HCLK);
                    @(negedge HCLK);
                    wait_mode = rows[r].mode;
                end
            end
            prev_stall = (rows[r].mode == wait_stall);
        end
        @(negedge tft_vsync);
        close_frame();
        $display("test passed");
        $finish;
    end

endmodule

// File: tft.sv
module tft (
    input  logic            HCLK,
    input  logic            HRESET,

    output ahb_pkg::addr_t  haddr,
    output ahb_pkg::burst_t hburst,
    output ahb_pkg::size_t  hsize,
    output ahb_pkg::trans_t htrans,
    output logic            hwrite,
    output ahb_pkg::data_t  hwdata,
    input  ahb_pkg::data_t  hrdata,
    input  logic            hready,
    input  ahb_pkg::resp_t  hresp,

    input  logic            clk_tft,
    input  logic            reset_tft,
    output logic            underflow,

    output logic            tft_dclk,
    output logic            tft_disp,
    output logic            tft_hsync,
    output logic            tft_vsync,
    output tft_pkg::pixel_t tft_rgb
);
    import ahb_pkg::*;

    data_t dma_data;
    logic  dma_req;
    logic  dma_ack;

    data_t rd_data;
    logic  rd_req;
    logic  rd_ack;

    logic  vsync_event;
    logic  vsync_meta;
    logic  vsync_ahb;

    // Frame start into HCLK
    always_ff @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            vsync_meta <= 1'b0;
            vsync_ahb  <= 1'b0;
        end else begin
            vsync_meta <= vsync_event;
            vsync_ahb  <= vsync_meta;
        end
    end

    tft_dma u_dma (
        .HCLK      (HCLK),
        .HRESET    (HRESET),
        .haddr     (haddr),
        .hburst    (hburst),
        .hsize     (hsize),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp),
        .dma_data  (dma_data),
        .dma_req   (dma_req),
        .dma_ack   (dma_ack),
        .vsync_ahb (vsync_ahb)
    );

    fifo_async u_fifo (
        .HCLK      (HCLK),
        .HRESET    (HRESET),
        .wr_data   (dma_data),
        .wr_req    (dma_req),
        .wr_ack    (dma_ack),
        .clk_tft   (clk_tft),
        .reset_tft (reset_tft),
        .rd_data   (rd_data),
        .rd_req    (rd_req),
        .rd_ack    (rd_ack)
    );

    tft_io u_io (
        .clk_tft     (clk_tft),
        .reset_tft   (reset_tft),
        .rd_data     (rd_data),
        .rd_req      (rd_req),
        .rd_ack      (rd_ack),
        .underflow   (underflow),
        .vsync_event (vsync_event),
        .tft_dclk    (tft_dclk),
        .tft_disp    (tft_disp),
        .tft_hsync   (tft_hsync),
        .tft_vsync   (tft_vsync),
        .tft_rgb     (tft_rgb)
    );

endmodule

// File: tft_dma.sv
module tft_dma (
    input  logic            HCLK,
    input  logic            HRESET,

    output ahb_pkg::addr_t  haddr,
    output ahb_pkg::burst_t hburst,
    output ahb_pkg::size_t  hsize,
    output ahb_pkg::trans_t htrans,
    output logic            hwrite,
    output ahb_pkg::data_t  hwdata,
    input  ahb_pkg::data_t  hrdata,
    input  logic            hready,
    input  ahb_pkg::resp_t  hresp,

    output ahb_pkg::data_t  dma_data,
    output logic            dma_req,
    input  logic            dma_ack,

    input  logic            vsync_ahb
);
    import ahb_pkg::*;
    import tft_pkg::*;

    dma_state_t            state;
    addr_t                 addr;
    logic [word_cnt_w-1:0] count;
    logic                  last_word;
    logic                  vsync_q;
    logic                  vsync_rise;

    assign vsync_rise = vsync_ahb && !vsync_q;
    assign last_word  = (count == word_cnt_w'(frame_words - 1));

    always_ff @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            vsync_q <= 1'b0;
        end else begin
            vsync_q <= vsync_ahb;
        end
    end

    always_ff @(posedge HCLK, posedge HRESET) begin
        if (HRESET) begin
            state <= st_idle;
            addr  <= frame_base;
            count <= '0;
        end else if (vsync_rise) begin
            // New frame restarts from the base, even mid-fetch
            state <= st_addr;
            addr  <= frame_base;
            count <= '0;
        end else begin
            case (state)
                st_addr: begin
                    if (hready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (hready) begin
                        state <= st_push;
                    end
                end
                st_push: begin
                    // Next address only once the FIFO took the word
                    if (dma_ack) begin
                        addr  <= addr + 32'd4;
                        count <= count + 1'b1;
                        if (last_word) begin
                            state <= st_idle;
                        end else begin
                            state <= st_addr;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Error response reads as zero
    always_ff @(posedge HCLK) begin
        if (state == st_data && hready) begin
            if (hresp == resp_error) begin
                dma_data <= '0;
            end else begin
                dma_data <= hrdata;
            end
        end
    end

    assign dma_req = (state == st_push);

    // Single word reads only
    assign haddr  = addr;
    assign htrans = (state == st_addr) ? trans_nonseq : trans_idle;
    assign hburst = burst_single;
    assign hsize  = size_word;
    assign hwrite = 1'b0;
    assign hwdata = '0;

endmodule

// File: tft_io.sv
module tft_io (
    input  logic            clk_tft,
    input  logic            reset_tft,

    input  ahb_pkg::data_t  rd_data,
    input  logic            rd_req,
    output logic            rd_ack,

    output logic            underflow,
    output logic            vsync_event,

    output logic            tft_dclk,
    output logic            tft_disp,
    output logic            tft_hsync,
    output logic            tft_vsync,
    output tft_pkg::pixel_t tft_rgb
);
    import tft_pkg::*;

    tft_region_t        h_region;
    tft_region_t        v_region;
    logic [h_cnt_w-1:0] h_cnt;
    logic [v_cnt_w-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               line_end;
    logic               active;
    logic               pop;

    function automatic int region_len(input logic vert, input tft_region_t r);
        case (r)
            reg_sync: return vert ? v_sync : h_sync;
            reg_back: return vert ? v_back : h_back;
            reg_disp: return vert ? v_disp : h_disp;
            default:  return vert ? v_front : h_front;
        endcase
    endfunction

    assign h_last   = (h_cnt == h_cnt_w'(region_len(1'b0, h_region) - 1));
    assign v_last   = (v_cnt == v_cnt_w'(region_len(1'b1, v_region) - 1));
    assign line_end = h_last && (h_region == reg_front);

    // Front porch wraps back to sync
    always_ff @(posedge clk_tft, posedge reset_tft) begin
        if (reset_tft) begin
            h_region <= reg_sync;
            h_cnt    <= '0;
            v_region <= reg_sync;
            v_cnt    <= '0;
        end else begin
            if (h_last) begin
                h_region <= tft_region_t'(h_region + 2'd1);
                h_cnt    <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (line_end) begin
                if (v_last) begin
                    v_region <= tft_region_t'(v_region + 2'd1);
                    v_cnt    <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    // Panel outputs trail the counters by one clock
    always_ff @(posedge clk_tft, posedge reset_tft) begin
        if (reset_tft) begin
            tft_disp  <= 1'b0;
            tft_hsync <= 1'b1;
            tft_vsync <= 1'b1;
            active    <= 1'b0;
        end else begin
            tft_disp  <= 1'b1;
            tft_hsync <= (h_region != reg_sync);
            tft_vsync <= (v_region != reg_sync);
            active    <= (h_region == reg_disp) && (v_region == reg_disp);
        end
    end

    assign rd_ack    = active;
    assign pop       = active && rd_req;
    assign underflow = active && !rd_req;
    assign tft_rgb   = pop ? rd_data[tft_width-1:0] : '0;

    assign vsync_event = !tft_vsync;
    assign tft_dclk    = !clk_tft;

endmodule

// File: tft_pkg.sv
package tft_pkg;

    // Horizontal timing in panel clocks
    localparam int h_sync  = 2;
    localparam int h_back  = 2;
    localparam int h_disp  = 8;
    localparam int h_front = 2;
    localparam int h_total = h_sync + h_back + h_disp + h_front;

    // Vertical timing in lines
    localparam int v_sync  = 1;
    localparam int v_back  = 1;
    localparam int v_disp  = 4;
    localparam int v_front = 1;
    localparam int v_total = v_sync + v_back + v_disp + v_front;

    localparam int h_cnt_w = $clog2(h_total);
    localparam int v_cnt_w = $clog2(v_total);

    localparam int tft_width = 24;

    // Frame buffer, one 32-bit word per pixel
    localparam ahb_pkg::addr_t frame_base = 32'h0000_1000;
    localparam int frame_words = h_disp * v_disp;
    localparam int word_cnt_w  = $clog2(frame_words);

    localparam int fifo_depth = 16;
    localparam int fifo_aw    = $clog2(fifo_depth);

    typedef logic [tft_width-1:0] pixel_t;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_push
    } dma_state_t;

    // Same region order on both axes
    typedef enum logic [1:0] {
        reg_sync,
        reg_back,
        reg_disp,
        reg_front
    } tft_region_t;

endpackage

// File: verilog.f
ahb_pkg.sv
tft_pkg.sv
fifo_async.sv
tft_dma.sv
tft_io.sv
tft.sv
tb_ahb_memory.sv
tb_tft.sv
